// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_lfb_entry
FILELIST = compile.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) design/lfb_settings.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+design
design/lfb_pkg.sv
design/lfb_entry_fsm.sv
design/lfb_entry_payload.sv
design/lfb_dep_check.sv
design/lfb_req_format.sv
design/lfb_entry.sv
sim/tb_lfb_entry.sv

// File: design/lfb_dep_check.sv
// Hazard compares of pipeline and prefetch requests against one entry.
// Purely combinational; every hit is qualified by entry_vld.
// Partial address compare only, so false hits are possible by design.
`include "lfb_settings.svh"

module lfb_dep_check (
  input  logic           entry_vld,
  input  logic           ld,
  input  logic           pf,
  input  logic           ca,
  input  lfb_pkg::attr_t attr,
  input  lfb_pkg::pa_t   pa,
  input  lfb_pkg::preg_t dest_reg,
  input  lfb_pkg::pa_t   dc_pa,
  input  lfb_pkg::preg_t dc_dest_preg,
  input  lfb_pkg::pa_t   pfb_pa,
  output logic           dc_hit_idx,
  output logic           dc_hit_addr,
  output logic           dc_hit_so,
  output logic           dc_hit_preg,
  output logic           pfb_hit_idx
);

  localparam int IDX_MSB = `LFB_LINE_LSB + `LFB_IDX_WIDTH - 1;

  // cache set index and line address
  assign dc_hit_idx  = entry_vld
                    && (dc_pa[IDX_MSB:`LFB_LINE_LSB] == pa[IDX_MSB:`LFB_LINE_LSB]);
  assign dc_hit_addr = entry_vld
                    && (dc_pa[`LFB_ADDR_HIT_MSB:`LFB_LINE_LSB]
                        == pa[`LFB_ADDR_HIT_MSB:`LFB_LINE_LSB]);

  // strongly-ordered load blocks younger accesses
  assign dc_hit_so   = entry_vld && ld && attr[`LFB_ATTR_SO];
  assign dc_hit_preg = entry_vld && ld && !pf && (dc_dest_preg == dest_reg);

  // prefetch only cares about lines that will land in the cache
  assign pfb_hit_idx = entry_vld && ca
                    && (pfb_pa[IDX_MSB:`LFB_LINE_LSB] == pa[IDX_MSB:`LFB_LINE_LSB]);

endmodule

// File: design/lfb_entry.sv
// One load fill buffer entry: FSM, held payload, hazard checker and
// request formatter. Clocked directly by lfb_fsm_clk, no clock gating.
// Instance ports connect by name; rdl_req_alias_hit is the alias flag
// sent with the RDL request, rdl_alias_hit the one RDL returns.
`include "lfb_settings.svh"

module lfb_entry (
  input  logic               lfb_fsm_clk,
  input  logic               cpurst_b,
  // create
  input  logic               create_en,
  input  logic               create_pf,
  input  logic               create_ld,
  input  logic               create_ca,
  input  logic               create_wb,
  input  lfb_pkg::pa_t       create_pa,
  input  lfb_pkg::attr_t     create_attr,
  input  logic [1:0]         create_size,
  input  logic [1:0]         create_priv_mode,
  input  lfb_pkg::preg_t     create_dest_reg,
  input  lfb_pkg::stbid_t    create_stbid,
  input  logic               create_alias_hit,
  input  logic [1:0]         create_virt_idx,
  // rdl
  input  logic               rdl_grant,
  input  logic               rdl_cmplt,
  input  logic               rdl_cache_hit,
  input  logic               rdl_alias_hit,
  input  lfb_pkg::fifo_ptr_t rdl_ref_fifo,
  output logic               rdl_req,
  output logic [`LFB_PADDR-1:`LFB_LINE_LSB] rdl_line_addr,
  output logic               rdl_req_alias_hit,
  // bus
  input  logic               bus_grant,
  input  logic               bus_cmplt,
  input  logic               bus_acc_err,
  output logic               arvalid,
  output lfb_pkg::pa_t       ar_addr,
  output logic [1:0]         ar_len,
  output lfb_pkg::ar_size_t  ar_size,
  output lfb_pkg::ar_cache_t ar_cache,
  output lfb_pkg::ar_prot_t  ar_prot,
  output logic               ar_user,
  output logic               ar_ld_inst,
  // dependency
  input  lfb_pkg::pa_t       dc_pa,
  input  lfb_pkg::preg_t     dc_dest_preg,
  input  lfb_pkg::pa_t       pfb_pa,
  output logic               dc_hit_idx,
  output logic               dc_hit_addr,
  output logic               dc_hit_so,
  output logic               dc_hit_preg,
  output logic               pfb_hit_idx,
  // entry status, refill, reports
  output logic               entry_vld,
  output logic               pop_en,
  output logic               bus_rdy,
  output logic               ref_en,
  output logic [1:0]         ref_cnt,
  output logic [`LFB_IDX_WIDTH-1:0] ref_idx,
  output logic               ld_wb_en,
  output logic               ld_wo_stall,
  output logic               ref_done,
  output logic               st_err,
  output lfb_pkg::stbid_t    st_stbid,
  output lfb_pkg::fifo_ptr_t st_ref_fifo
);

  lfb_pkg::lfb_state_t state;
  logic                refill_done;

  // held entry fields
  logic               pf;
  logic               ld;
  logic               ca;
  logic               wb;
  lfb_pkg::pa_t       pa;
  lfb_pkg::attr_t     attr;
  logic [1:0]         size;
  logic [1:0]         priv_mode;
  lfb_pkg::preg_t     dest_reg;
  lfb_pkg::stbid_t    stbid;
  logic [1:0]         virt_idx;
  logic               alias_hit;
  lfb_pkg::fifo_ptr_t ref_fifo;
  logic               ref_err;
  logic               wb_en;

  lfb_entry_fsm u_fsm (.*);

  lfb_entry_payload u_payload (.*);

  lfb_dep_check u_dep_check (.*);

  lfb_req_format u_req_format (
    .rdl_alias_hit (rdl_req_alias_hit),
    .*
  );

endmodule

// File: design/lfb_entry_fsm.sv
// Entry state machine for one load fill buffer slot.
// create_en must only arrive while the entry is idle.
// pf and ca are the held request flags and are stable while busy.
// Grants and completions are single-cycle strobes; a missing one
// simply stalls the entry in its current state.
module lfb_entry_fsm (
  input  logic               lfb_fsm_clk,
  input  logic               cpurst_b,
  input  logic               create_en,
  input  logic               rdl_grant,
  input  logic               rdl_cmplt,
  input  logic               rdl_cache_hit,
  input  logic               bus_grant,
  input  logic               bus_cmplt,
  input  logic               pf,
  input  logic               ca,
  output lfb_pkg::lfb_state_t state,
  output logic               entry_vld,
  output logic               pop_en,
  output logic               bus_rdy,
  output logic               refill_done
);

  lfb_pkg::lfb_state_t next_state;
  logic                pf_hit_done;

  // ====================================================================
  // state register and next-state decode
  // ====================================================================
  always_ff @(posedge lfb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state <= lfb_pkg::idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      lfb_pkg::idle:     if (create_en) next_state = lfb_pkg::wait_rdl;
      lfb_pkg::wait_rdl: if (rdl_grant) next_state = lfb_pkg::rdl;
      lfb_pkg::rdl: begin
        if (rdl_cmplt) begin
          next_state = (pf && rdl_cache_hit) ? lfb_pkg::idle : lfb_pkg::req_bus;
        end
      end
      lfb_pkg::req_bus:  if (bus_grant) next_state = lfb_pkg::ref_1;
      // single beat for non-cacheable requests
      lfb_pkg::ref_1:    if (bus_cmplt) next_state = ca ? lfb_pkg::ref_2 : lfb_pkg::idle;
      lfb_pkg::ref_2:    if (bus_cmplt) next_state = lfb_pkg::ref_3;
      lfb_pkg::ref_3:    if (bus_cmplt) next_state = lfb_pkg::ref_4;
      lfb_pkg::ref_4:    if (bus_cmplt) next_state = lfb_pkg::idle;
      default:           next_state = lfb_pkg::idle;
    endcase
  end

  // ====================================================================
  // strobes
  // ====================================================================
  // prefetch that already hit in the cache retires at rdl completion
  assign pf_hit_done = (state == lfb_pkg::rdl) && rdl_cmplt && pf && rdl_cache_hit;
  assign refill_done = (state == lfb_pkg::ref_4) && bus_cmplt;

  assign entry_vld = (state != lfb_pkg::idle);
  assign pop_en    = pf_hit_done
                   || ((state == lfb_pkg::ref_1) && bus_cmplt && !ca)
                   || refill_done;
  assign bus_rdy   = pf_hit_done || ((state == lfb_pkg::req_bus) && bus_grant);

  // allocator must not reuse a busy entry
  a_create_idle: assert property (@(posedge lfb_fsm_clk) disable iff (!cpurst_b)
    create_en |-> (state == lfb_pkg::idle))
    else $error("create_en while entry busy");

  // beats only return after the read was granted
  a_cmplt_in_ref: assert property (@(posedge lfb_fsm_clk) disable iff (!cpurst_b)
    bus_cmplt |-> state[2])
    else $error("bus_cmplt outside refill");

endmodule

// File: design/lfb_entry_payload.sv
// Held request fields of one load fill buffer entry.
// The request fields load only on create_en and carry no reset;
// they are meaningless while the entry is idle.
// alias_hit and ref_fifo are replaced by the RDL result in rdl.
module lfb_entry_payload (
  input  logic                lfb_fsm_clk,
  input  logic                cpurst_b,
  input  logic                create_en,
  input  logic                create_pf,
  input  logic                create_ld,
  input  logic                create_ca,
  input  logic                create_wb,
  input  lfb_pkg::pa_t        create_pa,
  input  lfb_pkg::attr_t      create_attr,
  input  logic [1:0]          create_size,
  input  logic [1:0]          create_priv_mode,
  input  lfb_pkg::preg_t      create_dest_reg,
  input  lfb_pkg::stbid_t     create_stbid,
  input  logic                create_alias_hit,
  input  logic [1:0]          create_virt_idx,
  input  lfb_pkg::lfb_state_t state,
  input  logic                rdl_cmplt,
  input  logic                rdl_alias_hit,
  input  lfb_pkg::fifo_ptr_t  rdl_ref_fifo,
  input  logic                bus_cmplt,
  input  logic                bus_acc_err,
  output logic                pf,
  output logic                ld,
  output logic                ca,
  output logic                wb,
  output lfb_pkg::pa_t        pa,
  output lfb_pkg::attr_t      attr,
  output logic [1:0]          size,
  output logic [1:0]          priv_mode,
  output lfb_pkg::preg_t      dest_reg,
  output lfb_pkg::stbid_t     stbid,
  output logic [1:0]          virt_idx,
  output logic                alias_hit,
  output lfb_pkg::fifo_ptr_t  ref_fifo,
  output logic                ref_err,
  output logic                wb_en
);

  logic rdl_done;

  assign rdl_done = rdl_cmplt && (state == lfb_pkg::rdl);

  // ====================================================================
  // request capture
  // ====================================================================
  always_ff @(posedge lfb_fsm_clk) begin
    if (create_en) begin
      pf        <= create_pf;
      ld        <= create_ld;
      ca        <= create_ca;
      wb        <= create_wb;
      pa        <= create_pa;
      attr      <= create_attr;
      size      <= create_size;
      priv_mode <= create_priv_mode;
      dest_reg  <= create_dest_reg;
      stbid     <= create_stbid;
      virt_idx  <= create_virt_idx;
    end
  end

  // ====================================================================
  // rdl result, refill error, write-back enable
  // ====================================================================
  always_ff @(posedge lfb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      alias_hit <= 1'b0;
      ref_fifo  <= '0;
      ref_err   <= 1'b0;
      wb_en     <= 1'b0;
    end else begin
      if (create_en) begin
        alias_hit <= create_alias_hit;
      end else if (rdl_done) begin
        alias_hit <= rdl_alias_hit;
      end
      if (rdl_done) begin
        ref_fifo <= rdl_ref_fifo;
      end
      // sticky over the whole refill
      if (create_en) begin
        ref_err <= 1'b0;
      end else if (bus_cmplt && bus_acc_err) begin
        ref_err <= 1'b1;
      end
      if (create_en) begin
        wb_en <= create_ld && !create_pf;
      end
    end
  end

  // the fifo pointer is only taken from an rdl completion seen in rdl
  a_cmplt_in_rdl: assert property (@(posedge lfb_fsm_clk) disable iff (!cpurst_b)
    rdl_cmplt |-> (state == lfb_pkg::rdl))
    else $error("rdl_cmplt outside rdl");

endmodule

// File: design/lfb_pkg.sv
// Types shared by the load fill buffer entry.
// The refill states keep bit 2 set so the low two bits act as the
// beat counter; the encoding must not be reordered.
`include "lfb_settings.svh"

package lfb_pkg;

  // ====================================================================
  // entry state
  // ====================================================================
  typedef enum logic [2:0] {
    idle     = 3'b000,
    wait_rdl = 3'b001,
    rdl      = 3'b010,
    req_bus  = 3'b011,
    ref_1    = 3'b100,
    ref_2    = 3'b101,
    ref_3    = 3'b110,
    ref_4    = 3'b111
  } lfb_state_t;

  // ====================================================================
  // request fields
  // ====================================================================
  typedef logic [`LFB_PADDR-1:0]       pa_t;
  typedef logic [2:0]                  attr_t;
  typedef logic [`LFB_PREG_WIDTH-1:0]  preg_t;
  typedef logic [`LFB_FIFO_WIDTH-1:0]  fifo_ptr_t;
  typedef logic [`LFB_STBID_WIDTH-1:0] stbid_t;

  // bus read channel fields
  typedef logic [3:0] ar_cache_t;
  typedef logic [2:0] ar_prot_t;
  typedef logic [2:0] ar_size_t;

endpackage

// File: design/lfb_req_format.sv
// Request fields towards RDL, the bus read channel, the refill unit
// and the store buffer, all derived from the held entry.
// Combinational only. Strongly-ordered requests keep their own size
// and low address bits; all others read a full 16-byte beat.
`include "lfb_settings.svh"

module lfb_req_format (
  input  lfb_pkg::lfb_state_t state,
  input  lfb_pkg::pa_t        pa,
  input  lfb_pkg::attr_t      attr,
  input  logic [1:0]          size,
  input  logic [1:0]          priv_mode,
  input  logic                ld,
  input  logic                pf,
  input  logic                ca,
  input  logic                wb,
  input  logic                alias_hit,
  input  logic [1:0]          virt_idx,
  input  lfb_pkg::stbid_t     stbid,
  input  lfb_pkg::fifo_ptr_t  ref_fifo,
  input  logic                ref_err,
  input  logic                wb_en,
  input  logic                refill_done,
  input  logic                bus_acc_err,
  output logic                rdl_req,
  output logic [`LFB_PADDR-1:`LFB_LINE_LSB] rdl_line_addr,
  output logic                rdl_alias_hit,
  output logic                arvalid,
  output lfb_pkg::pa_t        ar_addr,
  output logic [1:0]          ar_len,
  output lfb_pkg::ar_size_t   ar_size,
  output lfb_pkg::ar_cache_t  ar_cache,
  output lfb_pkg::ar_prot_t   ar_prot,
  output logic                ar_user,
  output logic                ar_ld_inst,
  output logic                ref_en,
  output logic [1:0]          ref_cnt,
  output logic [`LFB_IDX_WIDTH-1:0] ref_idx,
  output logic                ld_wb_en,
  output logic                ld_wo_stall,
  output logic                ref_done,
  output logic                st_err,
  output lfb_pkg::stbid_t     st_stbid,
  output lfb_pkg::fifo_ptr_t  st_ref_fifo
);

  logic so;
  logic buf_bit;

  assign so      = attr[`LFB_ATTR_SO];
  assign buf_bit = ca ? wb : attr[`LFB_ATTR_BUF];

  // ====================================================================
  // rdl request
  // ====================================================================
  assign rdl_req       = (state == lfb_pkg::wait_rdl);
  assign rdl_line_addr = pa[`LFB_PADDR-1:`LFB_LINE_LSB];
  assign rdl_alias_hit = alias_hit;

  // ====================================================================
  // bus read
  // ====================================================================
  assign arvalid    = (state == lfb_pkg::req_bus);
  assign ar_addr    = {pa[`LFB_PADDR-1:4], so ? pa[3:0] : 4'b0000};
  assign ar_len     = ca ? 2'(`LFB_LINE_BEATS - 1) : 2'b00;
  assign ar_size    = so ? {1'b0, size} : 3'b100;
  assign ar_cache   = {ca, ca, !so, buf_bit};
  assign ar_prot    = {1'b0, 1'b1, priv_mode[0]};
  assign ar_user    = priv_mode[1];
  assign ar_ld_inst = ld && !pf;

  // ====================================================================
  // refill and reports
  // ====================================================================
  // an error beat stops further cache writes of this line
  assign ref_en  = ca && !ref_err;
  assign ref_cnt = state[1:0];
  assign ref_idx = {virt_idx, pa[`LFB_LINE_LSB+`LFB_IDX_WIDTH-3:`LFB_LINE_LSB]};

  assign ld_wb_en    = wb_en && (state == lfb_pkg::ref_1);
  assign ld_wo_stall = ar_ld_inst && !so && ((state == lfb_pkg::req_bus) || state[2]);

  // store refill report
  assign ref_done    = refill_done && !ld && !pf;
  assign st_err      = ref_err || bus_acc_err;
  assign st_stbid    = stbid;
  assign st_ref_fifo = ref_fifo;

endmodule

// File: design/lfb_settings.svh
// Widths and bit positions shared by the load fill buffer entry.
// The index compare and the refill index assume a 64-byte line.
// Attribute positions follow the page attribute order ca, so, buf.
`ifndef LFB_SETTINGS_SVH
`define LFB_SETTINGS_SVH

// physical address and line layout
`define LFB_PADDR        40
`define LFB_LINE_LSB     6
`define LFB_IDX_WIDTH    8
`define LFB_ADDR_HIT_MSB 21

// ids and pointers
`define LFB_PREG_WIDTH   6
`define LFB_STBID_WIDTH  2
`define LFB_FIFO_WIDTH   4

// attribute bit positions
`define LFB_ATTR_CA      0
`define LFB_ATTR_SO      1
`define LFB_ATTR_BUF     2

// beats per cacheable refill
`define LFB_LINE_BEATS   4

`endif

// File: sim/tb_lfb_entry.sv
// Testbench for one load fill buffer entry.
// Table rows run back to back; RDL and the bus are answered after 0 to 3
// idle cycles taken from an LFSR. Outputs are sampled on the falling edge.
// The run stops at the first wrong value or at the cycle limit.
`include "lfb_settings.svh"

module tb_lfb_entry;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NROWS       = 5;
  localparam int CYCLE_LIMIT = NROWS * 40 + 50;

  typedef struct {
    logic                pf;
    logic                ld;
    logic                ca;
    logic                wb;
    lfb_pkg::pa_t        pa;
    lfb_pkg::attr_t      attr;
    logic [1:0]          size;
    logic [1:0]          priv;
    lfb_pkg::preg_t      dest;
    lfb_pkg::stbid_t     stbid;
    logic                cache_hit;
    int                  err_beat;
    int                  beats;
    logic [1:0]          ar_len;
    lfb_pkg::ar_size_t   ar_size;
    lfb_pkg::ar_cache_t  ar_cache;
    lfb_pkg::pa_t        ar_addr;
    logic                ref_done;
    logic                st_err;
  } row_t;

  logic lfb_fsm_clk;
  logic cpurst_b;
  logic create_en, create_pf, create_ld, create_ca, create_wb, create_alias_hit;
  lfb_pkg::pa_t create_pa;
  lfb_pkg::attr_t create_attr;
  logic [1:0] create_size, create_priv_mode, create_virt_idx;
  lfb_pkg::preg_t create_dest_reg;
  lfb_pkg::stbid_t create_stbid;
  logic rdl_grant, rdl_cmplt, rdl_cache_hit, rdl_alias_hit;
  lfb_pkg::fifo_ptr_t rdl_ref_fifo;
  logic rdl_req, rdl_req_alias_hit;
  logic [`LFB_PADDR-1:`LFB_LINE_LSB] rdl_line_addr;
  logic bus_grant, bus_cmplt, bus_acc_err;
  logic arvalid, ar_user, ar_ld_inst;
  lfb_pkg::pa_t ar_addr;
  logic [1:0] ar_len;
  lfb_pkg::ar_size_t ar_size;
  lfb_pkg::ar_cache_t ar_cache;
  lfb_pkg::ar_prot_t ar_prot;
  lfb_pkg::pa_t dc_pa, pfb_pa;
  lfb_pkg::preg_t dc_dest_preg;
  logic dc_hit_idx, dc_hit_addr, dc_hit_so, dc_hit_preg, pfb_hit_idx;
  logic entry_vld, pop_en, bus_rdy, ref_en, ld_wb_en, ld_wo_stall, ref_done, st_err;
  logic [1:0] ref_cnt;
  logic [`LFB_IDX_WIDTH-1:0] ref_idx;
  lfb_pkg::stbid_t st_stbid;
  lfb_pkg::fifo_ptr_t st_ref_fifo;

  row_t         rows [NROWS];
  lfb_pkg::pa_t dep_mask [4];
  logic         dep_idx [4];
  logic         dep_addr [4];
  logic [31:0]  lfsr = 32'h86fa2029;
  int           cycle_count = 0;

  lfb_entry dut (.*);

  initial begin
    lfb_fsm_clk = 1'b0;
    forever #2 lfb_fsm_clk = ~lfb_fsm_clk;
  end

  // ====================================================================
  // failure reporting, checks, random delays
  // ====================================================================
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge lfb_fsm_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      fail_run($sformatf("entry did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input lfb_pkg::pa_t got,
                            input lfb_pkg::pa_t exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_cache(input string name, input lfb_pkg::ar_cache_t got,
                             input lfb_pkg::ar_cache_t exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_size(input string name, input lfb_pkg::ar_size_t got,
                            input lfb_pkg::ar_size_t exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_prot(input string name, input lfb_pkg::ar_prot_t got,
                            input lfb_pkg::ar_prot_t exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_cnt(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_idx(input string name, input logic [`LFB_IDX_WIDTH-1:0] got,
                           input logic [`LFB_IDX_WIDTH-1:0] exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_fifo(input string name, input lfb_pkg::fifo_ptr_t got,
                            input lfb_pkg::fifo_ptr_t exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_stbid(input string name, input lfb_pkg::stbid_t got,
                             input lfb_pkg::stbid_t exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  // galois lfsr stepped once per bit
  task automatic take_bits(input int n, output int val);
    int k;
    val = 0;
    for (k = 0; k < n; k++) begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
  endtask

  task automatic wait_random();
    int d;
    take_bits(2, d);
    repeat (d) @(posedge lfb_fsm_clk);
  endtask

  // ====================================================================
  // per-row sequence
  // ====================================================================
  task automatic check_hits_clear();
    check_bit("dc_hit_idx", dc_hit_idx, 1'b0);
    check_bit("dc_hit_addr", dc_hit_addr, 1'b0);
    check_bit("dc_hit_so", dc_hit_so, 1'b0);
    check_bit("dc_hit_preg", dc_hit_preg, 1'b0);
    check_bit("pfb_hit_idx", pfb_hit_idx, 1'b0);
  endtask

  // index, line address and register compares while the entry waits on rdl
  task automatic probe_dependencies(input row_t r);
    int k;
    for (k = 0; k < 4; k++) begin
      @(posedge lfb_fsm_clk);
      dc_pa        <= r.pa ^ dep_mask[k];
      pfb_pa       <= r.pa ^ dep_mask[k];
      dc_dest_preg <= (k % 2 == 1) ? (r.dest ^ 6'h01) : r.dest;
      @(negedge lfb_fsm_clk);
      check_bit("dc_hit_idx", dc_hit_idx, dep_idx[k]);
      check_bit("dc_hit_addr", dc_hit_addr, dep_addr[k]);
      check_bit("dc_hit_so", dc_hit_so, r.ld && r.attr[`LFB_ATTR_SO]);
      check_bit("dc_hit_preg", dc_hit_preg, r.ld && !r.pf && (k % 2 == 0));
      check_bit("pfb_hit_idx", pfb_hit_idx, r.ca && dep_idx[k]);
    end
    @(posedge lfb_fsm_clk);
    dc_pa        <= r.pa;
    pfb_pa       <= r.pa;
    dc_dest_preg <= r.dest;
  endtask

  task automatic run_row(input int i);
    row_t               r;
    lfb_pkg::fifo_ptr_t fifo;
    logic               pf_hit;
    logic               alias_in;
    int                 b;
    r        = rows[i];
    fifo     = 4'(9 + 3 * i);
    pf_hit   = r.pf && r.cache_hit;
    alias_in = (i % 2 == 1);
    @(posedge lfb_fsm_clk);
    create_en        <= 1'b1;
    create_pf        <= r.pf;
    create_ld        <= r.ld;
    create_ca        <= r.ca;
    create_wb        <= r.wb;
    create_pa        <= r.pa;
    create_attr      <= r.attr;
    create_size      <= r.size;
    create_priv_mode <= r.priv;
    create_dest_reg  <= r.dest;
    create_stbid     <= r.stbid;
    create_virt_idx  <= ~r.pa[13:12];
    create_alias_hit <= alias_in;
    @(negedge lfb_fsm_clk);
    check_bit("rdl_req", rdl_req, 1'b0);
    @(posedge lfb_fsm_clk);
    create_en <= 1'b0;
    @(negedge lfb_fsm_clk);
    check_bit("rdl_req", rdl_req, 1'b1);
    check_bit("entry_vld", entry_vld, 1'b1);
    probe_dependencies(r);

    wait_random();
    @(posedge lfb_fsm_clk);
    rdl_grant <= 1'b1;
    @(negedge lfb_fsm_clk);
    check_bit("rdl_req", rdl_req, 1'b1);
    check_bit("rdl_req_alias_hit", rdl_req_alias_hit, alias_in);
    check_addr("rdl_line_addr", {rdl_line_addr, 6'h00},
               {r.pa[`LFB_PADDR-1:`LFB_LINE_LSB], 6'h00});
    @(posedge lfb_fsm_clk);
    rdl_grant <= 1'b0;
    wait_random();
    @(posedge lfb_fsm_clk);
    rdl_cmplt     <= 1'b1;
    rdl_cache_hit <= r.cache_hit;
    rdl_ref_fifo  <= fifo;
    rdl_alias_hit <= !alias_in;
    @(negedge lfb_fsm_clk);
    check_bit("pop_en", pop_en, pf_hit);
    check_bit("bus_rdy", bus_rdy, pf_hit);
    @(posedge lfb_fsm_clk);
    rdl_cmplt     <= 1'b0;
    rdl_cache_hit <= 1'b0;
    rdl_alias_hit <= 1'b0;

    if (!pf_hit) begin
      @(negedge lfb_fsm_clk);
      while (!arvalid) @(negedge lfb_fsm_clk);
      check_cnt("ar_len", ar_len, r.ar_len);
      check_size("ar_size", ar_size, r.ar_size);
      check_cache("ar_cache", ar_cache, r.ar_cache);
      check_addr("ar_addr", ar_addr, r.ar_addr);
      check_prot("ar_prot", ar_prot, {1'b0, 1'b1, r.priv[0]});
      check_bit("ar_user", ar_user, r.priv[1]);
      check_bit("ar_ld_inst", ar_ld_inst, r.ld && !r.pf);
      check_idx("ref_idx", ref_idx, {~r.pa[13:12], r.pa[11:6]});
      // alias flag now comes from the rdl answer
      check_bit("rdl_req_alias_hit", rdl_req_alias_hit, !alias_in);
      wait_random();
      @(posedge lfb_fsm_clk);
      bus_grant <= 1'b1;
      @(negedge lfb_fsm_clk);
      check_bit("arvalid", arvalid, 1'b1);
      check_bit("bus_rdy", bus_rdy, 1'b1);
      @(posedge lfb_fsm_clk);
      bus_grant <= 1'b0;
      for (b = 0; b < r.beats; b++) begin
        wait_random();
        @(posedge lfb_fsm_clk);
        bus_cmplt   <= 1'b1;
        bus_acc_err <= (b == r.err_beat);
        @(negedge lfb_fsm_clk);
        check_cnt("ref_cnt", ref_cnt, 2'(b));
        check_bit("ref_en", ref_en, r.ca && !(r.err_beat >= 0 && b > r.err_beat));
        check_bit("ld_wb_en", ld_wb_en, (b == 0) && r.ld && !r.pf);
        check_bit("pop_en", pop_en, b == r.beats - 1);
        check_bit("ref_done", ref_done, (b == r.beats - 1) && r.ref_done);
        if (r.attr[`LFB_ATTR_SO]) check_bit("ld_wo_stall", ld_wo_stall, 1'b0);
        if (b == r.beats - 1) begin
          check_bit("st_err", st_err, r.st_err);
          if (!r.ld) begin
            check_fifo("st_ref_fifo", st_ref_fifo, fifo);
            check_stbid("st_stbid", st_stbid, r.stbid);
          end
        end
        @(posedge lfb_fsm_clk);
        bus_cmplt   <= 1'b0;
        bus_acc_err <= 1'b0;
      end
    end

    // entry retired so nothing may still hit
    @(negedge lfb_fsm_clk);
    check_bit("entry_vld", entry_vld, 1'b0);
    check_bit("arvalid", arvalid, 1'b0);
    check_hits_clear();
  endtask

  // ====================================================================
  // stimulus table and main sequence
  // ====================================================================
  initial begin
    // pf ld ca wb pa attr size priv dest stbid hit err beats
    // ar_len ar_size ar_cache ar_addr ref_done st_err
    rows[0] = '{0, 1, 1, 1, 40'h12_3456_789A, 3'b001, 2'b10, 2'b11, 6'h15, 2'd0, 0, -1, 4,
                2'd3, 3'd4, 4'hF, 40'h12_3456_7890, 0, 0};
    rows[1] = '{1, 1, 1, 0, 40'h00_0ABC_DE40, 3'b001, 2'b11, 2'b00, 6'h2A, 2'd1, 1, -1, 0,
                2'd3, 3'd4, 4'hE, 40'h00_0ABC_DE40, 0, 0};
    rows[2] = '{0, 1, 0, 0, 40'h80_0000_1234, 3'b110, 2'b01, 2'b01, 6'h07, 2'd0, 0, -1, 1,
                2'd0, 3'd1, 4'h1, 40'h80_0000_1234, 0, 0};
    rows[3] = '{0, 0, 1, 1, 40'h3F_FFFF_F0C8, 3'b001, 2'b11, 2'b00, 6'h00, 2'd2, 0, 1, 4,
                2'd3, 3'd4, 4'hF, 40'h3F_FFFF_F0C0, 1, 1};
    rows[4] = '{0, 0, 0, 0, 40'h45_6789_ABCD, 3'b100, 2'b10, 2'b10, 6'h31, 2'd3, 0, 0, 1,
                2'd0, 3'd4, 4'h3, 40'h45_6789_ABC0, 0, 1};
    // same line, bit 14 outside the index, bit 6 in both, bit 30 in neither
    dep_mask = '{40'h0, 40'h4000, 40'h40, 40'h4000_0000};
    dep_idx  = '{1'b1, 1'b1, 1'b0, 1'b1};
    dep_addr = '{1'b1, 1'b0, 1'b0, 1'b1};

    cpurst_b         = 1'b0;
    create_en        = 1'b0;
    create_pf        = 1'b0;
    create_ld        = 1'b0;
    create_ca        = 1'b0;
    create_wb        = 1'b0;
    create_alias_hit = 1'b0;
    create_pa        = '0;
    create_attr      = '0;
    create_size      = '0;
    create_priv_mode = '0;
    create_virt_idx  = '0;
    create_dest_reg  = '0;
    create_stbid     = '0;
    rdl_grant        = 1'b0;
    rdl_cmplt        = 1'b0;
    rdl_cache_hit    = 1'b0;
    rdl_alias_hit    = 1'b0;
    rdl_ref_fifo     = '0;
    bus_grant        = 1'b0;
    bus_cmplt        = 1'b0;
    bus_acc_err      = 1'b0;
    dc_pa            = '0;
    pfb_pa           = '0;
    dc_dest_preg     = '0;

    repeat (3) @(posedge lfb_fsm_clk);
    cpurst_b <= 1'b1;
    @(negedge lfb_fsm_clk);
    check_bit("entry_vld", entry_vld, 1'b0);
    check_bit("rdl_req", rdl_req, 1'b0);

    for (int i = 0; i < NROWS; i++) begin
      run_row(i);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule
